//--- list.f
+incdir+hdl
hdl/video_pkg.sv
hdl/video_timing.sv
hdl/video_regs.sv
hdl/video_bitmap_fetch.sv
hdl/video_pixel_out.sv
hdl/video_gen.sv
sim/video_gen_sva.sv
sim/video_gen_tb.sv

//--- Makefile
# Verilator build and run of the video generator testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := video_gen_tb
FILE_LIST := list.f
OBJ_DIR   := obj_dir
RUN_FLAGS := +verilator+error+limit+100
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/video_gen_tb.sv
/*
 * Testbench for the video generator: clock, reset, VRAM model and
 * directed tests of readback, blanking, bitmap, border and interrupt.
 */
`timescale 1ns/1ns
`include "video_macros.svh"

module video_gen_tb
    import video_pkg::*;
();

    localparam int FRAME_CYCLES   = `VID_H_TOTAL * `VID_V_TOTAL;
    localparam int DE_PER_FRAME   = `VID_H_VISIBLE * `VID_V_VISIBLE;
    localparam int TIMEOUT_CYCLES = 4000;               // the tests need about 13 frames

    logic       clk;
    logic       reset_i;
    logic       vgen_reg_wr_en_i;
    reg_num_t   vgen_reg_num_i;
    word_t      vgen_reg_data_i;
    word_t      vgen_reg_data_o;
    logic       video_intr_o;
    logic       vram_sel_o;
    addr_t      vram_addr_o;
    word_t      vram_data_i;
    color_t     colorA_index_o;
    logic       hsync_o;
    logic       vsync_o;
    logic       h_blank_o;
    logic       v_blank_o;
    logic       dv_de_o;

    int         errors = 0;
    int         checks = 0;
    int         tests_failed = 0;
    int         cycles = 0;
    logic       rd_pending = 1'b0;
    addr_t      rd_addr = '0;

    // register state as the tests have written it
    color_t     exp_border;
    logic       exp_blank;
    color_t     exp_base;
    addr_t      exp_start;
    word_t      exp_len;
    int         exp_left;
    int         exp_right;

    video_gen DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // memory contents, low byte mixes in the upper address
    function automatic word_t vram_word(addr_t a);
        return {a[7:0], ~a[7:0] ^ a[15:8]};
    endfunction

    always @(posedge clk) begin
        #10;
        vram_data_i = rd_pending ? vram_word(rd_addr) : '0;    // one clock read latency
        rd_pending  = vram_sel_o;
        rd_addr     = vram_addr_o;
    end

    function automatic color_t expect_pixel(int x, int y);
        addr_t  a;
        word_t  w;
        color_t b;
        a = exp_start + addr_t'(y) * exp_len + addr_t'(x / 2);
        w = vram_word(a);
        b = (x % 2 == 0) ? w[15:8] : w[7:0];           // even column is the high byte
        if (exp_blank || x < exp_left || x >= exp_right) begin
            return exp_border;
        end
        return b ^ exp_base;
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_color(string name, color_t got, color_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic write_reg(reg_num_t num, word_t data);
        @(posedge clk);
        #10;
        vgen_reg_wr_en_i = 1'b1;
        vgen_reg_num_i   = num;
        vgen_reg_data_i  = data;
        @(posedge clk);
        #10;
        vgen_reg_wr_en_i = 1'b0;
    endtask

    task automatic read_reg(input reg_num_t num, output word_t data);
        @(posedge clk);
        #10;
        vgen_reg_num_i = num;
        @(posedge clk);                                 // readback registered here
        @(negedge clk);
        data = vgen_reg_data_o;
    endtask

    // skips the frame in progress, then checks every pixel and sync level of the next one
    task automatic check_frame();
        int n;
        int i;
        int col;
        int line;
        n = 0;
        @(negedge clk);
        while (v_blank_o) @(negedge clk);
        while (!v_blank_o) @(negedge clk);
        while (v_blank_o) @(negedge clk);
        for (i = 0; i < FRAME_CYCLES; i++) begin
            col  = i % `VID_H_TOTAL;
            line = i / `VID_H_TOTAL;
            check_bit("hsync_o", hsync_o,
                      col >= `VID_H_FRONT && col < `VID_H_FRONT + `VID_H_SYNC);
            check_bit("vsync_o", vsync_o, line == `VID_V_VISIBLE + `VID_V_FRONT);
            check_bit("h_blank_o", h_blank_o, col < `VID_H_OFFSCREEN);
            check_bit("v_blank_o", v_blank_o, line >= `VID_V_VISIBLE);
            check_bit("dv_de_o", dv_de_o, col >= `VID_H_OFFSCREEN && line < `VID_V_VISIBLE);
            if (dv_de_o) begin
                check_color("colorA_index_o", colorA_index_o,
                            expect_pixel(n % `VID_H_VISIBLE, n / `VID_H_VISIBLE));
                n++;
            end else begin
                check_color("colorA_index_o", colorA_index_o, 8'h00);
            end
            @(negedge clk);
        end
        check_count("dv_de_o cycles", n, DE_PER_FRAME);
    endtask

    task automatic report_test(string name, int errors_before);
        if (errors == errors_before) begin
            $display("%0t ns  %s: ok", $time, name);
        end else begin
            tests_failed++;
            $display("%0t ns  %s: %0d errors", $time, name, errors - errors_before);
        end
    endtask

    task automatic test_reset_readback();
        int     e0;
        word_t  d;
        word_t  s;
        e0 = errors;
        read_reg(`XR_VID_CTRL, d);
        check_word("VID_CTRL", d, 16'h0008);
        read_reg(`XR_VID_LEFT, d);
        check_word("VID_LEFT", d, 16'h0000);
        read_reg(`XR_VID_RIGHT, d);
        check_word("VID_RIGHT", d, 16'h0010);
        read_reg(`XR_PA_GFX_CTRL, d);
        check_word("PA_GFX_CTRL", d, 16'h0080);        // blank set, color base 0
        read_reg(`XR_PA_DISP_ADDR, d);
        check_word("PA_DISP_ADDR", d, 16'h0000);
        read_reg(`XR_PA_LINE_LEN, d);
        check_word("PA_LINE_LEN", d, 16'h0008);
        read_reg(`XR_VID_HSIZE, d);
        check_word("VID_HSIZE", d, 16'h0010);
        read_reg(`XR_VID_VSIZE, d);
        check_word("VID_VSIZE", d, 16'h0008);
        read_reg(6'h01, d);
        check_word("unused register 0x01", d, 16'h0000);
        // one line later the scanline has moved on by one, wrapping at the frame
        read_reg(`XR_SCANLINE, s);
        repeat (`VID_V_TOTAL) begin
            repeat (`VID_H_TOTAL) @(negedge clk);
            d = vgen_reg_data_o;
            check_word("SCANLINE", d, word_t'((s + 1) % `VID_V_TOTAL));
            s = d;
        end
        report_test("reset readback", e0);
    endtask

    task automatic test_blanked_output();
        int e0;
        e0 = errors;
        check_frame();
        exp_border = 8'h08 ^ color_t'(1 + $urandom % 255);     // never the reset color
        write_reg(`XR_VID_CTRL, word_t'(exp_border));
        check_frame();
        report_test("blanked output", e0);
    endtask

    task automatic test_bitmap_pixels();
        int     e0;
        word_t  d;
        e0 = errors;
        exp_blank = 1'b0;
        exp_base  = color_t'($urandom);
        exp_start = addr_t'($urandom);
        exp_len   = word_t'($urandom);
        write_reg(`XR_PA_GFX_CTRL, {exp_base, 1'b0, 7'h00});
        write_reg(`XR_PA_DISP_ADDR, exp_start);
        write_reg(`XR_PA_LINE_LEN, exp_len);
        read_reg(`XR_PA_DISP_ADDR, d);
        check_word("PA_DISP_ADDR", d, exp_start);
        read_reg(`XR_PA_LINE_LEN, d);
        check_word("PA_LINE_LEN", d, exp_len);
        check_frame();
        report_test("bitmap pixels", e0);
    endtask

    task automatic test_border_window();
        int e0;
        e0 = errors;
        exp_left  = $urandom % `VID_H_VISIBLE;
        exp_right = exp_left + 1 + ($urandom % (`VID_H_VISIBLE - exp_left));
        write_reg(`XR_VID_LEFT, word_t'(exp_left));
        write_reg(`XR_VID_RIGHT, word_t'(exp_right));
        check_frame();
        report_test("border window", e0);
    endtask

    task automatic test_interrupt();
        int e0;
        int pulses;
        e0 = errors;
        pulses = 0;
        repeat (2 * FRAME_CYCLES) begin
            @(negedge clk);
            if (video_intr_o) pulses++;
        end
        check_count("frame interrupts in two frames", pulses, 2);
        // write at the first visible pixel, far from the end of frame pulse
        @(negedge clk);
        while (!v_blank_o) @(negedge clk);
        while (!dv_de_o) @(negedge clk);
        write_reg(`XR_VID_INTR, 16'h0001);
        @(negedge clk);
        check_bit("video_intr_o", video_intr_o, 1'b1);
        @(negedge clk);
        check_bit("video_intr_o", video_intr_o, 1'b0);
        pulses = 0;
        repeat (FRAME_CYCLES) begin
            @(negedge clk);
            if (video_intr_o) pulses++;
        end
        check_count("frame interrupts after write", pulses, 1);
        report_test("interrupt", e0);
    endtask

    initial begin
        void'($urandom(26182));
        reset_i          = 1'b1;
        vgen_reg_wr_en_i = 1'b0;
        vgen_reg_num_i   = '0;
        vgen_reg_data_i  = '0;
        vram_data_i      = '0;
        exp_border       = 8'h08;
        exp_blank        = 1'b1;
        exp_base         = '0;
        exp_start        = '0;
        exp_len          = 16'h0008;
        exp_left         = 0;
        exp_right        = `VID_H_VISIBLE;
        repeat (8) @(posedge clk);
        #10;
        reset_i = 1'b0;

        test_reset_readback();
        test_blanked_output();
        test_bitmap_pixels();
        test_border_window();
        test_interrupt();

        errors += DUT.u_sva.assert_fail_count;
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 5, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- sim/video_gen_sva.sv
/*
 * Assertions for the video generator, bound into video_gen:
 * interrupt pulse width, display enable vs blanking, no fetch in vblank.
 */
`timescale 1ns/1ns
`include "video_macros.svh"

module video_gen_sva (
    input  logic    clk,
    input  logic    reset_i,
    input  logic    video_intr_o,
    input  logic    dv_de_o,
    input  logic    h_blank_o,
    input  logic    v_blank_o,
    input  logic    vram_sel_o
);

    int     assert_fail_count = 0;
    int     vblank_run;                                 // clocks of v_blank_o high, saturating

    always_ff @(posedge clk) begin
        if (reset_i || !v_blank_o) begin
            vblank_run <= 0;
        end else if (vblank_run < `VID_H_TOTAL) begin
            vblank_run <= vblank_run + 1;
        end
    end

    intr_one_clock: assert property (@(posedge clk) disable iff (reset_i)
        video_intr_o |=> !video_intr_o)
        else begin
            assert_fail_count++;
            $error("video_intr_o high for two clocks in a row");
        end

    de_not_blank: assert property (@(posedge clk) disable iff (reset_i)
        dv_de_o |-> (!h_blank_o && !v_blank_o))
        else begin
            assert_fail_count++;
            $error("dv_de_o high while a blank output is high");
        end

    // a whole line of vertical blank means no visible line is being fetched
    no_fetch_in_vblank: assert property (@(posedge clk) disable iff (reset_i)
        (vblank_run >= `VID_H_TOTAL) |-> !vram_sel_o)
        else begin
            assert_fail_count++;
            $error("vram_sel_o high during vertical blank");
        end

endmodule

bind video_gen video_gen_sva u_sva (
    .clk            (clk),
    .reset_i        (reset_i),
    .video_intr_o   (video_intr_o),
    .dv_de_o        (dv_de_o),
    .h_blank_o      (h_blank_o),
    .v_blank_o      (v_blank_o),
    .vram_sel_o     (vram_sel_o)
);

//--- hdl/video_gen.sv
/*
 * Video generator top level: timing, registers, bitmap fetch and
 * output stage.
 */
`timescale 1ns/1ns

module video_gen
    import video_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  logic        vgen_reg_wr_en_i,
    input  reg_num_t    vgen_reg_num_i,
    input  word_t       vgen_reg_data_i,
    output word_t       vgen_reg_data_o,
    output logic        video_intr_o,
    output logic        vram_sel_o,
    output addr_t       vram_addr_o,
    input  word_t       vram_data_i,
    output color_t      colorA_index_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        h_blank_o,
    output logic        v_blank_o,
    output logic        dv_de_o
);

    raster_t    raster;
    vid_cfg_t   vid_cfg;
    pf_cfg_t    pf_cfg;
    color_t     pix_index;
    logic       pix_valid;

    video_timing u_timing (
        .clk            (clk),
        .reset_i        (reset_i),
        .raster_o       (raster)
    );

    video_regs u_regs (
        .clk                (clk),
        .reset_i            (reset_i),
        .vgen_reg_wr_en_i   (vgen_reg_wr_en_i),
        .vgen_reg_num_i     (vgen_reg_num_i),
        .vgen_reg_data_i    (vgen_reg_data_i),
        .raster_i           (raster),
        .vid_cfg_o          (vid_cfg),
        .pf_cfg_o           (pf_cfg),
        .vgen_reg_data_o    (vgen_reg_data_o),
        .video_intr_o       (video_intr_o)
    );

    video_bitmap_fetch u_fetch (
        .clk            (clk),
        .reset_i        (reset_i),
        .raster_i       (raster),
        .pf_cfg_i       (pf_cfg),
        .vram_sel_o     (vram_sel_o),
        .vram_addr_o    (vram_addr_o),
        .vram_data_i    (vram_data_i),
        .pix_index_o    (pix_index),
        .pix_valid_o    (pix_valid)
    );

    video_pixel_out u_pixel_out (
        .clk            (clk),
        .reset_i        (reset_i),
        .raster_i       (raster),
        .vid_cfg_i      (vid_cfg),
        .pix_index_i    (pix_index),
        .pix_valid_i    (pix_valid),
        .colorA_index_o (colorA_index_o),
        .hsync_o        (hsync_o),
        .vsync_o        (vsync_o),
        .h_blank_o      (h_blank_o),
        .v_blank_o      (v_blank_o),
        .dv_de_o        (dv_de_o)
    );

endmodule

//--- hdl/video_pixel_out.sv
/*
 * Output stage: raster delay to match the pixel pipeline, border
 * window and border color select, registered video outputs.
 */
`timescale 1ns/1ns
`include "video_macros.svh"

module video_pixel_out
    import video_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  raster_t     raster_i,
    input  vid_cfg_t    vid_cfg_i,
    input  color_t      pix_index_i,
    input  logic        pix_valid_i,
    output color_t      colorA_index_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        h_blank_o,
    output logic        v_blank_o,
    output logic        dv_de_o
);

    // raster fields carried down the delay line
    typedef struct packed {
        logic   h_visible;
        logic   v_visible;
        logic   hsync;
        logic   vsync;
        hres_t  col;                    // visible column
    } tap_t;

    tap_t   tap_in;
    tap_t   tap_q [`VID_PIX_LAT];
    tap_t   tap;
    logic   de;
    logic   in_window;

    always_comb begin
        tap_in.h_visible = raster_i.h_visible;
        tap_in.v_visible = raster_i.v_visible;
        tap_in.hsync     = raster_i.hsync;
        tap_in.vsync     = raster_i.vsync;
        tap_in.col       = raster_i.h_count - hres_t'(`VID_H_OFFSCREEN);
    end

    assign tap       = tap_q[`VID_PIX_LAT-1];          // lines up with pix_index_i
    assign de        = tap.h_visible & tap.v_visible;
    assign in_window = (tap.col >= vid_cfg_i.left) && (tap.col < vid_cfg_i.right);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `VID_PIX_LAT; i++) begin
                tap_q[i] <= '0;
            end
            colorA_index_o  <= '0;
            hsync_o         <= 1'b0;
            vsync_o         <= 1'b0;
            h_blank_o       <= 1'b1;
            v_blank_o       <= 1'b1;
            dv_de_o         <= 1'b0;
        end else begin
            tap_q[0] <= tap_in;
            for (int i = 1; i < `VID_PIX_LAT; i++) begin
                tap_q[i] <= tap_q[i-1];
            end
            hsync_o     <= tap.hsync;
            vsync_o     <= tap.vsync;
            h_blank_o   <= ~tap.h_visible;
            v_blank_o   <= ~tap.v_visible;
            dv_de_o     <= de;
            if (!de) begin
                colorA_index_o <= '0;                   // black outside display
            end else if (pix_valid_i && in_window) begin
                colorA_index_o <= pix_index_i;
            end else begin
                colorA_index_o <= vid_cfg_i.border_color;
            end
        end
    end

endmodule

//--- hdl/video_bitmap_fetch.sv
/*
 * Bitmap fetch: line and word addressing, windowed VRAM reads and
 * unpacking of two 8 bit pixels per word with the color base xor.
 */
`timescale 1ns/1ns
`include "video_macros.svh"

module video_bitmap_fetch
    import video_pkg::*;
(
    input  logic    clk,
    input  logic    reset_i,
    input  raster_t raster_i,
    input  pf_cfg_t pf_cfg_i,
    output logic    vram_sel_o,
    output addr_t   vram_addr_o,
    input  word_t   vram_data_i,        // valid the clock after the request
    output color_t  pix_index_o,
    output logic    pix_valid_o
);

    // the last read of a line covers the last two visible columns
    localparam hres_t FETCH_START = hres_t'(`VID_H_OFFSCREEN - `VID_FETCH_LEAD);
    localparam hres_t FETCH_END   = hres_t'(`VID_H_TOTAL - `VID_FETCH_LEAD);

    hres_t  fetch_rel;
    logic   fetch_win;
    logic   fetch_go;
    addr_t  line_addr;                  // first word of current line
    addr_t  word_addr;                  // next word to read
    addr_t  next_line;
    word_t  len_q;                      // line length for this frame
    logic   data_ok;                    // vram_data_i holds a word
    logic   word_ok;                    // word_q just loaded
    logic   shift_hi;
    logic   shift_lo;
    word_t  word_q;
    word_t  shift_q;

    assign fetch_rel = raster_i.h_count - FETCH_START;
    assign fetch_win = raster_i.v_visible && !pf_cfg_i.blank &&
                       (raster_i.h_count >= FETCH_START) && (raster_i.h_count < FETCH_END);
    assign fetch_go  = fetch_win && !fetch_rel[0];     // every second clock
    assign next_line = line_addr + len_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_sel_o  <= 1'b0;
            vram_addr_o <= '0;
            line_addr   <= '0;
            word_addr   <= '0;
            len_q       <= '0;
            data_ok     <= 1'b0;
            word_ok     <= 1'b0;
            shift_hi    <= 1'b0;
            shift_lo    <= 1'b0;
            pix_valid_o <= 1'b0;
        end else begin
            vram_sel_o <= fetch_go;
            if (fetch_go) begin
                vram_addr_o <= word_addr;
                word_addr   <= word_addr + 1'b1;
            end
            if (raster_i.end_of_frame) begin
                line_addr   <= pf_cfg_i.start_addr;    // new frame settings
                word_addr   <= pf_cfg_i.start_addr;
                len_q       <= pf_cfg_i.line_len;
            end else if (raster_i.end_of_line && raster_i.v_visible) begin
                line_addr   <= next_line;
                word_addr   <= next_line;
            end
            data_ok     <= vram_sel_o;
            word_ok     <= data_ok;
            shift_hi    <= word_ok;
            shift_lo    <= shift_hi;
            pix_valid_o <= shift_hi | shift_lo;
        end
    end

    // word capture and byte shift out, high byte first
    always_ff @(posedge clk) begin
        if (data_ok) begin
            word_q <= vram_data_i;
        end
        if (word_ok) begin
            shift_q <= word_q;
        end else begin
            shift_q <= {shift_q[7:0], 8'h00};
        end
        pix_index_o <= shift_q[15:8] ^ pf_cfg_i.color_base;
    end

endmodule

//--- hdl/video_regs.sv
/*
 * Video register block: register writes into the configuration
 * structs, registered readback and the video interrupt pulse.
 */
`timescale 1ns/1ns
`include "video_macros.svh"

module video_regs
    import video_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  logic        vgen_reg_wr_en_i,   // one clock write strobe
    input  reg_num_t    vgen_reg_num_i,
    input  word_t       vgen_reg_data_i,
    input  raster_t     raster_i,
    output vid_cfg_t    vid_cfg_o,
    output pf_cfg_t     pf_cfg_o,
    output word_t       vgen_reg_data_o,    // readback, one clock later
    output logic        video_intr_o
);

    word_t  rd_data;
    logic   intr_wr;

    assign intr_wr = vgen_reg_wr_en_i && (vgen_reg_num_i == `XR_VID_INTR);

    // configuration writes
    always_ff @(posedge clk) begin
        if (reset_i) begin
            vid_cfg_o.border_color  <= 8'h08;           // grey, shows the design is alive
            vid_cfg_o.left          <= '0;
            vid_cfg_o.right         <= hres_t'(`VID_H_VISIBLE);
            pf_cfg_o.blank          <= 1'b1;            // playfield off until enabled
            pf_cfg_o.color_base     <= '0;
            pf_cfg_o.start_addr     <= '0;
            pf_cfg_o.line_len       <= word_t'(8);
        end else if (vgen_reg_wr_en_i) begin
            case (vgen_reg_num_i)
                `XR_VID_CTRL: begin
                    vid_cfg_o.border_color  <= vgen_reg_data_i[7:0];
                end
                `XR_VID_LEFT: begin
                    vid_cfg_o.left          <= vgen_reg_data_i[4:0];
                end
                `XR_VID_RIGHT: begin
                    vid_cfg_o.right         <= vgen_reg_data_i[4:0];
                end
                `XR_PA_GFX_CTRL: begin
                    pf_cfg_o.color_base     <= vgen_reg_data_i[15:8];
                    pf_cfg_o.blank          <= vgen_reg_data_i[7];
                end
                `XR_PA_DISP_ADDR: begin
                    pf_cfg_o.start_addr     <= vgen_reg_data_i;
                end
                `XR_PA_LINE_LEN: begin
                    pf_cfg_o.line_len       <= vgen_reg_data_i;
                end
                default: begin
                end
            endcase
        end
    end

    // readback mux, unused numbers read 0
    always_comb begin
        rd_data = '0;
        case (vgen_reg_num_i)
            `XR_VID_CTRL:       rd_data = word_t'(vid_cfg_o.border_color);
            `XR_VID_LEFT:       rd_data = word_t'(vid_cfg_o.left);
            `XR_VID_RIGHT:      rd_data = word_t'(vid_cfg_o.right);
            `XR_SCANLINE:       rd_data = word_t'(raster_i.v_count);
            `XR_VID_HSIZE:      rd_data = word_t'(`VID_H_VISIBLE);
            `XR_VID_VSIZE:      rd_data = word_t'(`VID_V_VISIBLE);
            `XR_PA_GFX_CTRL:    rd_data = {pf_cfg_o.color_base, pf_cfg_o.blank, 7'h00};
            `XR_PA_DISP_ADDR:   rd_data = pf_cfg_o.start_addr;
            `XR_PA_LINE_LEN:    rd_data = pf_cfg_o.line_len;
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        vgen_reg_data_o <= rd_data;                     // level read, no strobe
    end

    // frame interrupt or software kick
    always_ff @(posedge clk) begin
        if (reset_i) begin
            video_intr_o <= 1'b0;
        end else begin
            video_intr_o <= raster_i.end_of_visible | intr_wr;
        end
    end

endmodule

//--- hdl/video_timing.sv
/*
 * Raster timing: horizontal and vertical counters with sync,
 * visibility and end of line, frame and visible area decode.
 */
`timescale 1ns/1ns
`include "video_macros.svh"

module video_timing
    import video_pkg::*;
(
    input  logic    clk,
    input  logic    reset_i,
    output raster_t raster_o
);

    localparam hres_t H_LAST      = hres_t'(`VID_H_TOTAL - 1);
    localparam hres_t H_VIS_START = hres_t'(`VID_H_OFFSCREEN);
    localparam hres_t H_SYNC_ON   = hres_t'(`VID_H_FRONT);
    localparam hres_t H_SYNC_OFF  = hres_t'(`VID_H_FRONT + `VID_H_SYNC);
    localparam vres_t V_LAST      = vres_t'(`VID_V_TOTAL - 1);
    localparam vres_t V_VIS_LAST  = vres_t'(`VID_V_VISIBLE - 1);
    localparam vres_t V_SYNC_ON   = vres_t'(`VID_V_VISIBLE + `VID_V_FRONT);
    localparam vres_t V_SYNC_OFF  = vres_t'(`VID_V_VISIBLE + `VID_V_FRONT + `VID_V_SYNC);

    hres_t  h_count;
    vres_t  v_count;
    logic   h_last;
    logic   v_last;

    assign h_last = (h_count == H_LAST);
    assign v_last = (v_count == V_LAST);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_last) begin
            h_count <= '0;
            if (v_last) begin
                v_count <= '0;                          // wrap to top of frame
            end else begin
                v_count <= v_count + 1'b1;
            end
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // decode straight from the counter registers
    always_comb begin
        raster_o.h_count        = h_count;
        raster_o.v_count        = v_count;
        raster_o.h_visible      = (h_count >= H_VIS_START);
        raster_o.v_visible      = (v_count <= V_VIS_LAST);
        raster_o.end_of_line    = h_last;
        raster_o.end_of_frame   = h_last && v_last;
        raster_o.end_of_visible = h_last && (v_count == V_VIS_LAST);
        raster_o.hsync          = (h_count >= H_SYNC_ON) && (h_count < H_SYNC_OFF);
        raster_o.vsync          = (v_count >= V_SYNC_ON) && (v_count < V_SYNC_OFF);
    end

endmodule

//--- hdl/video_pkg.sv
/*
 * Shared types of the video generator: word, address, color and
 * counter vectors, plus configuration and raster structs.
 */
package video_pkg;

    typedef logic [15:0] word_t;        // register or memory word
    typedef logic [15:0] addr_t;        // vram word address
    typedef logic [7:0]  color_t;       // palette index
    typedef logic [4:0]  hres_t;        // horizontal counter
    typedef logic [3:0]  vres_t;        // vertical counter
    typedef logic [5:0]  reg_num_t;     // register number

    // output stage settings
    typedef struct packed {
        color_t border_color;
        hres_t  left;                   // first column inside window
        hres_t  right;                  // first column past window
    } vid_cfg_t;

    // playfield settings
    typedef struct packed {
        logic   blank;
        color_t color_base;             // xor applied to fetched pixels
        addr_t  start_addr;
        word_t  line_len;               // words per line
    } pf_cfg_t;

    // counters and their decode
    typedef struct packed {
        hres_t  h_count;
        vres_t  v_count;
        logic   h_visible;
        logic   v_visible;
        logic   end_of_line;
        logic   end_of_frame;
        logic   end_of_visible;         // last clock of last visible line
        logic   hsync;
        logic   vsync;
    } raster_t;

endpackage

//--- hdl/video_macros.svh
/*
 * Raster timing, pixel pipeline latency and register number macros
 * for the bitmap video generator.
 */
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// horizontal timing in clocks, offscreen columns come first
`define VID_H_OFFSCREEN     8
`define VID_H_VISIBLE       16
`define VID_H_FRONT         2
`define VID_H_SYNC          2
`define VID_H_TOTAL         (`VID_H_OFFSCREEN + `VID_H_VISIBLE)

// vertical timing in lines, visible lines come first
`define VID_V_VISIBLE       8
`define VID_V_FRONT         1
`define VID_V_SYNC          1
`define VID_V_TOTAL         12

`define VID_PIX_LAT         3       // counter to pixel index at output stage
`define VID_FETCH_LEAD      2       // fetch starts this early

// register numbers
`define XR_VID_CTRL         6'h00
`define XR_VID_INTR         6'h03
`define XR_VID_LEFT         6'h04
`define XR_VID_RIGHT        6'h05
`define XR_SCANLINE         6'h08
`define XR_VID_HSIZE        6'h0A
`define XR_VID_VSIZE        6'h0B
`define XR_PA_GFX_CTRL      6'h10
`define XR_PA_DISP_ADDR     6'h12
`define XR_PA_LINE_LEN      6'h13

`endif
